// ==== logic/issue_pkg.sv ====
// --------------------
// shared widths and encodings of the issue stage
// XLEN is only the default, the top level parameter overrides it
// fu_t value NONE doubles as "not clobbered" in the clobber table
// --------------------

`default_nettype none

package issue_pkg;

    // default data width
    localparam int unsigned XLEN = 32;

    // register file geometry
    localparam int unsigned REG_ADDR_BITS = 5;
    localparam int unsigned NR_REGS       = 32;

    // scoreboard transaction id width
    localparam int unsigned TRANS_ID_BITS = 3;

    // rs1 and rs2
    localparam int unsigned NR_SRC = 2;

    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    // functional unit of an instruction, or the unit that clobbers a register
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        CSR,
        MULT,
        LOAD,
        STORE
    } fu_t;

    // operator code, passed through to execute untouched
    typedef logic [7:0] op_t;

endpackage

`default_nettype wire

// ==== logic/int_regfile.sv ====
// --------------------
// integer register file, x0 reads as zero and is never written
// reads are combinational, a write is visible the cycle after we_i
// on an address collision the higher-numbered commit port wins
// --------------------

`timescale 1ns/1ps
`default_nettype none

module int_regfile import issue_pkg::*; #(
    parameter int unsigned XLEN            = issue_pkg::XLEN,
    parameter int unsigned NR_READ_PORTS   = 2,
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  wire logic                                        clk_i,
    input  wire logic                                        rst_ni,
    // read side
    input  wire reg_addr_t [NR_READ_PORTS-1:0]               raddr_i,
    output logic           [NR_READ_PORTS-1:0][XLEN-1:0]     rdata_o,
    // commit write ports
    input  wire reg_addr_t [NR_COMMIT_PORTS-1:0]             waddr_i,
    input  wire logic      [NR_COMMIT_PORTS-1:0][XLEN-1:0]   wdata_i,
    input  wire logic      [NR_COMMIT_PORTS-1:0]             we_i
);

    logic [XLEN-1:0] mem [NR_REGS];

    // x0 is hardwired
    assign mem[0] = '0;

    // --------------------
    // write ports
    // --------------------
    for (genvar r = 1; r < NR_REGS; r++) begin : gen_reg
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                mem[r] <= '0;
            end else begin
                // later ports override earlier ones in the same cycle
                for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                    if (we_i[p] && (waddr_i[p] == reg_addr_t'(r))) begin
                        mem[r] <= wdata_i[p];
                    end
                end
            end
        end
    end

    // --------------------
    // read ports
    // --------------------
    always_comb begin
        for (int unsigned i = 0; i < NR_READ_PORTS; i++) begin
            rdata_o[i] = mem[raddr_i[i]];
        end
    end

endmodule

`default_nettype wire

// ==== logic/operand_fetch.sv ====
// --------------------
// operand fetch for one source register, purely combinational
// clobber_i must be the clobber table entry at src_i
// CSR results cannot be forwarded, such a source always stalls
// --------------------

`timescale 1ns/1ps
`default_nettype none

module operand_fetch import issue_pkg::*; #(
    parameter int unsigned XLEN = issue_pkg::XLEN
) (
    // source index and its clobber entry
    input  wire reg_addr_t        src_i,
    input  wire fu_t              clobber_i,
    // scoreboard result for this source
    input  wire logic [XLEN-1:0]  fwd_data_i,
    input  wire logic             fwd_valid_i,
    // architectural value
    input  wire logic [XLEN-1:0]  regfile_data_i,
    // source is not a register read (zimm), no hazard possible
    input  wire logic             ignore_i,
    output logic      [XLEN-1:0]  operand_o,
    output logic                  stall_o
);

    logic clobbered;
    logic can_forward;

    // x0 never waits on anything
    assign clobbered = !ignore_i && (src_i != '0) && (clobber_i != NONE);

    // forward only a finished, non-CSR result
    assign can_forward = fwd_valid_i && (clobber_i != CSR);

    // --------------------
    // forward or stall
    // --------------------
    always_comb begin
        operand_o = regfile_data_i;
        stall_o   = 1'b0;
        if (clobbered) begin
            if (can_forward) begin
                operand_o = fwd_data_i;
            end else begin
                // value still in flight
                stall_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/issue_control.sv ====
// --------------------
// issue acknowledge, operand overrides and the ID/EX registers
// exception and NONE instructions are acked even when stalled
// right after a multiply only another multiply is acked
// --------------------

`timescale 1ns/1ps
`default_nettype none

module issue_control import issue_pkg::*; #(
    parameter int unsigned XLEN            = issue_pkg::XLEN,
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  wire logic                                   clk_i,
    input  wire logic                                   rst_ni,
    input  wire logic                                   flush_i,
    // instruction from upstream
    input  wire logic                                   issue_valid_i,
    input  wire fu_t                                    issue_fu_i,
    input  wire op_t                                    issue_op_i,
    input  wire reg_addr_t                              issue_rs1_i,
    input  wire reg_addr_t                              issue_rd_i,
    input  wire logic      [XLEN-1:0]                   issue_imm_i,
    input  wire logic      [XLEN-1:0]                   issue_pc_i,
    input  wire logic                                   issue_use_imm_i,
    input  wire logic                                   issue_use_pc_i,
    input  wire logic                                   issue_use_zimm_i,
    input  wire logic                                   issue_ex_valid_i,
    input  wire trans_id_t                              issue_trans_id_i,
    output logic                                        issue_ack_o,
    // clobber entry of rd and commit ports for the WAW check
    input  wire fu_t                                    rd_clobber_i,
    input  wire reg_addr_t [NR_COMMIT_PORTS-1:0]        waddr_i,
    input  wire logic      [NR_COMMIT_PORTS-1:0]        we_i,
    // fetched operands
    input  wire logic      [NR_SRC-1:0][XLEN-1:0]       operand_i,
    input  wire logic      [NR_SRC-1:0]                 stall_i,
    // unit readies
    input  wire logic                                   flu_ready_i,
    input  wire logic                                   lsu_ready_i,
    // toward execute
    output logic           [XLEN-1:0]                   operand_a_o,
    output logic           [XLEN-1:0]                   operand_b_o,
    output logic           [XLEN-1:0]                   imm_o,
    output logic           [XLEN-1:0]                   pc_o,
    output fu_t                                         fu_o,
    output op_t                                         op_o,
    output trans_id_t                                   trans_id_o,
    output logic                                        alu_valid_o,
    output logic                                        branch_valid_o,
    output logic                                        lsu_valid_o,
    output logic                                        mult_valid_o,
    output logic                                        csr_valid_o
);

    logic            fu_busy;
    logic            waw_free;
    logic [XLEN-1:0] operand_a_d;
    logic [XLEN-1:0] operand_b_d;

    // --------------------
    // issue check
    // --------------------

    // busy depends on which unit the instruction needs
    always_comb begin
        unique case (issue_fu_i)
            ALU, CTRL_FLOW, CSR, MULT: fu_busy = !flu_ready_i;
            LOAD, STORE:               fu_busy = !lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // rd free, or released by a commit port this very cycle
    always_comb begin
        waw_free = (rd_clobber_i == NONE);
        for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
            if (we_i[i] && (waddr_i[i] == issue_rd_i)) begin
                waw_free = 1'b1;
            end
        end
    end

    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!(|stall_i) && !fu_busy && waw_free) begin
                issue_ack_o = 1'b1;
            end
            // nothing gets executed for these two, so no hazard applies
            if (issue_ex_valid_i || (issue_fu_i == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // multiplier result shares the fixed latency writeback
        if (mult_valid_o && (issue_fu_i != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    // --------------------
    // operand overrides
    // --------------------
    always_comb begin
        operand_a_d = operand_i[0];
        operand_b_d = operand_i[1];
        if (issue_use_pc_i) begin
            operand_a_d = issue_pc_i;
        end
        // zimm sits in the rs1 field, zero extended
        if (issue_use_zimm_i) begin
            operand_a_d = {{(XLEN-REG_ADDR_BITS){1'b0}}, issue_rs1_i};
        end
        // stores and branches need rs2 and keep imm on its own port
        if (issue_use_imm_i && (issue_fu_i != STORE) && (issue_fu_i != CTRL_FLOW)) begin
            operand_b_d = issue_imm_i;
        end
    end

    // --------------------
    // ID/EX registers
    // --------------------

    // one valid pulse per acknowledged instruction, killed by flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_o   <= 1'b0;
            csr_valid_o    <= 1'b0;
        end else begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_o   <= 1'b0;
            csr_valid_o    <= 1'b0;
            if (issue_valid_i && issue_ack_o && !issue_ex_valid_i && !flush_i) begin
                case (issue_fu_i)
                    ALU:         alu_valid_o    <= 1'b1;
                    CTRL_FLOW:   branch_valid_o <= 1'b1;
                    MULT:        mult_valid_o   <= 1'b1;
                    LOAD, STORE: lsu_valid_o    <= 1'b1;
                    CSR:         csr_valid_o    <= 1'b1;
                    default:     ;
                endcase
            end
        end
    end

    // data loads every cycle, only meaningful with a valid pulse
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            operand_a_o <= '0;
            operand_b_o <= '0;
            imm_o       <= '0;
            pc_o        <= '0;
            fu_o        <= NONE;
            op_o        <= '0;
            trans_id_o  <= '0;
        end else begin
            operand_a_o <= operand_a_d;
            operand_b_o <= operand_b_d;
            imm_o       <= issue_imm_i;
            pc_o        <= issue_pc_i;
            fu_o        <= issue_fu_i;
            op_o        <= issue_op_i;
            trans_id_o  <= issue_trans_id_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/issue_read_operands.sv ====
// --------------------
// issue and operand read stage of a single-issue in-order core
// fwd_data_i and fwd_valid_i must describe rs1 and rs2 of the current instruction
// execute outputs follow the acknowledge by exactly one cycle
// --------------------

`timescale 1ns/1ps
`default_nettype none

module issue_read_operands import issue_pkg::*; #(
    parameter int unsigned XLEN            = issue_pkg::XLEN,
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  wire logic                                   clk_i,
    input  wire logic                                   rst_ni,
    input  wire logic                                   flush_i,
    // instruction from upstream
    input  wire logic                                   issue_valid_i,
    input  wire fu_t                                    issue_fu_i,
    input  wire op_t                                    issue_op_i,
    input  wire reg_addr_t                              issue_rs1_i,
    input  wire reg_addr_t                              issue_rs2_i,
    input  wire reg_addr_t                              issue_rd_i,
    input  wire logic      [XLEN-1:0]                   issue_imm_i,
    input  wire logic      [XLEN-1:0]                   issue_pc_i,
    input  wire logic                                   issue_use_imm_i,
    input  wire logic                                   issue_use_pc_i,
    input  wire logic                                   issue_use_zimm_i,
    input  wire logic                                   issue_ex_valid_i,
    input  wire trans_id_t                              issue_trans_id_i,
    output logic                                        issue_ack_o,
    // scoreboard view
    input  wire fu_t       [NR_REGS-1:0]                rd_clobber_i,
    input  wire logic      [NR_SRC-1:0][XLEN-1:0]       fwd_data_i,
    input  wire logic      [NR_SRC-1:0]                 fwd_valid_i,
    // unit readies
    input  wire logic                                   flu_ready_i,
    input  wire logic                                   lsu_ready_i,
    // commit write ports
    input  wire reg_addr_t [NR_COMMIT_PORTS-1:0]        waddr_i,
    input  wire logic      [NR_COMMIT_PORTS-1:0][XLEN-1:0] wdata_i,
    input  wire logic      [NR_COMMIT_PORTS-1:0]        we_i,
    // toward execute
    output logic           [XLEN-1:0]                   operand_a_o,
    output logic           [XLEN-1:0]                   operand_b_o,
    output logic           [XLEN-1:0]                   imm_o,
    output logic           [XLEN-1:0]                   pc_o,
    output fu_t                                         fu_o,
    output op_t                                         op_o,
    output trans_id_t                                   trans_id_o,
    output logic                                        alu_valid_o,
    output logic                                        branch_valid_o,
    output logic                                        lsu_valid_o,
    output logic                                        mult_valid_o,
    output logic                                        csr_valid_o
);

    // source 0 is rs1, source 1 is rs2
    reg_addr_t [NR_SRC-1:0]             src_addr;
    logic      [NR_SRC-1:0][XLEN-1:0]   rf_data;
    logic      [NR_SRC-1:0][XLEN-1:0]   operand;
    logic      [NR_SRC-1:0]             stall;

    assign src_addr[0] = issue_rs1_i;
    assign src_addr[1] = issue_rs2_i;

    // --------------------
    // register file
    // --------------------
    int_regfile #(
        .XLEN            ( XLEN            ),
        .NR_READ_PORTS   ( NR_SRC          ),
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_int_regfile (
        .clk_i   ( clk_i    ),
        .rst_ni  ( rst_ni   ),
        .raddr_i ( src_addr ),
        .rdata_o ( rf_data  ),
        .waddr_i ( waddr_i  ),
        .wdata_i ( wdata_i  ),
        .we_i    ( we_i     )
    );

    // --------------------
    // operand fetch
    // --------------------
    for (genvar s = 0; s < NR_SRC; s++) begin : gen_fetch
        // only rs1 can carry a zimm instead of a register
        operand_fetch #(
            .XLEN ( XLEN )
        ) i_operand_fetch (
            .src_i          ( src_addr[s]                            ),
            .clobber_i      ( rd_clobber_i[src_addr[s]]              ),
            .fwd_data_i     ( fwd_data_i[s]                          ),
            .fwd_valid_i    ( fwd_valid_i[s]                         ),
            .regfile_data_i ( rf_data[s]                             ),
            .ignore_i       ( (s == 0) ? issue_use_zimm_i : 1'b0     ),
            .operand_o      ( operand[s]                             ),
            .stall_o        ( stall[s]                               )
        );
    end

    // --------------------
    // issue controller
    // --------------------
    issue_control #(
        .XLEN            ( XLEN            ),
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_issue_control (
        .clk_i            ( clk_i                      ),
        .rst_ni           ( rst_ni                     ),
        .flush_i          ( flush_i                    ),
        .issue_valid_i    ( issue_valid_i              ),
        .issue_fu_i       ( issue_fu_i                 ),
        .issue_op_i       ( issue_op_i                 ),
        .issue_rs1_i      ( issue_rs1_i                ),
        .issue_rd_i       ( issue_rd_i                 ),
        .issue_imm_i      ( issue_imm_i                ),
        .issue_pc_i       ( issue_pc_i                 ),
        .issue_use_imm_i  ( issue_use_imm_i            ),
        .issue_use_pc_i   ( issue_use_pc_i             ),
        .issue_use_zimm_i ( issue_use_zimm_i           ),
        .issue_ex_valid_i ( issue_ex_valid_i           ),
        .issue_trans_id_i ( issue_trans_id_i           ),
        .issue_ack_o      ( issue_ack_o                ),
        .rd_clobber_i     ( rd_clobber_i[issue_rd_i]   ),
        .waddr_i          ( waddr_i                    ),
        .we_i             ( we_i                       ),
        .operand_i        ( operand                    ),
        .stall_i          ( stall                      ),
        .flu_ready_i      ( flu_ready_i                ),
        .lsu_ready_i      ( lsu_ready_i                ),
        .operand_a_o      ( operand_a_o                ),
        .operand_b_o      ( operand_b_o                ),
        .imm_o            ( imm_o                      ),
        .pc_o             ( pc_o                       ),
        .fu_o             ( fu_o                       ),
        .op_o             ( op_o                       ),
        .trans_id_o       ( trans_id_o                 ),
        .alu_valid_o      ( alu_valid_o                ),
        .branch_valid_o   ( branch_valid_o             ),
        .lsu_valid_o      ( lsu_valid_o                ),
        .mult_valid_o     ( mult_valid_o               ),
        .csr_valid_o      ( csr_valid_o                )
    );

endmodule

`default_nettype wire

// ==== test/issue_read_operands_assert.sv ====
// --------------------
// bound checks on the execute valid pulses of issue_read_operands
// fail_count is read by the testbench at the end of the run
// --------------------

`timescale 1ns/1ps
`default_nettype none

module issue_read_operands_assert import issue_pkg::*; (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic flush_i,
    input wire logic issue_valid_i,
    input wire logic issue_ack_o,
    input wire fu_t  issue_fu_i,
    input wire logic alu_valid_o,
    input wire logic branch_valid_o,
    input wire logic lsu_valid_o,
    input wire logic mult_valid_o,
    input wire logic csr_valid_o
);

    int fail_count = 0;

    logic [4:0] valids;

    assign valids = {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o};

    // only one unit is started per cycle
    a_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(valids))
        else begin
            fail_count = fail_count + 1;
            $error("more than one valid output high");
        end

    // a flush in the ack cycle kills the pulse
    a_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(flush_i) |-> (valids == 5'b0))
        else begin
            fail_count = fail_count + 1;
            $error("valid output high in the cycle after flush");
        end

    // every pulse comes from an acknowledged instruction
    a_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valids != 5'b0) |-> $past(issue_valid_i && issue_ack_o))
        else begin
            fail_count = fail_count + 1;
            $error("valid output without an acknowledge one cycle earlier");
        end

    // behind a multiply only a multiply may issue
    a_mult: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mult_valid_o && issue_valid_i && issue_ack_o) |-> (issue_fu_i == MULT))
        else begin
            fail_count = fail_count + 1;
            $error("non-multiply acknowledged right after a multiply");
        end

endmodule

bind issue_read_operands issue_read_operands_assert i_issue_read_operands_assert (.*);

`default_nettype wire

// ==== test/tb_issue_read_operands.sv ====
// --------------------
// testbench of issue_read_operands with a shadow register file
// clobber table and forwarding data are driven directly without a scoreboard
// --------------------

`timescale 1ns/1ps
`default_nettype none

module tb_issue_read_operands import issue_pkg::*; ();

    localparam int unsigned W      = 32;
    localparam int unsigned NR_CP  = 2;
    localparam int          LIMIT  = 2000;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic flush_i;
    logic issue_valid_i;
    fu_t  issue_fu_i;
    op_t  issue_op_i;
    reg_addr_t issue_rs1_i;
    reg_addr_t issue_rs2_i;
    reg_addr_t issue_rd_i;
    logic [W-1:0] issue_imm_i;
    logic [W-1:0] issue_pc_i;
    logic issue_use_imm_i;
    logic issue_use_pc_i;
    logic issue_use_zimm_i;
    logic issue_ex_valid_i;
    trans_id_t issue_trans_id_i;
    logic issue_ack_o;
    fu_t [NR_REGS-1:0] rd_clobber_i;
    logic [NR_SRC-1:0][W-1:0] fwd_data_i;
    logic [NR_SRC-1:0] fwd_valid_i;
    logic flu_ready_i;
    logic lsu_ready_i;
    reg_addr_t [NR_CP-1:0] waddr_i;
    logic [NR_CP-1:0][W-1:0] wdata_i;
    logic [NR_CP-1:0] we_i;
    logic [W-1:0] operand_a_o;
    logic [W-1:0] operand_b_o;
    logic [W-1:0] imm_o;
    logic [W-1:0] pc_o;
    fu_t fu_o;
    op_t op_o;
    trans_id_t trans_id_o;
    logic alu_valid_o;
    logic branch_valid_o;
    logic lsu_valid_o;
    logic mult_valid_o;
    logic csr_valid_o;

    integer seed = 40059;
    int cycles = 0;
    logic [W-1:0] shadow [NR_REGS];

    issue_read_operands #(
        .XLEN            ( W     ),
        .NR_COMMIT_PORTS ( NR_CP )
    ) i_issue_read_operands (.*);

    always #20 clk_i = ~clk_i;

    // run limit of roughly ten times the test length
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // helpers
    // --------------------
    task automatic check(input string name, input logic [W-1:0] exp, input logic [W-1:0] act);
        if (exp !== act) begin
            $display("Error %s: expected %0h, actual %0h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // {alu, branch, lsu, mult, csr}
    function automatic logic [4:0] unit_valid(input fu_t fu);
        case (fu)
            ALU:         return 5'b10000;
            CTRL_FLOW:   return 5'b01000;
            LOAD, STORE: return 5'b00100;
            MULT:        return 5'b00010;
            CSR:         return 5'b00001;
            default:     return 5'b00000;
        endcase
    endfunction

    // expected source value from x0, a forward or the shadow file
    function automatic logic [W-1:0] source_value(input int s, input reg_addr_t r);
        if (r == 0) begin
            return '0;
        end
        if (rd_clobber_i[r] != NONE) begin
            return fwd_data_i[s];
        end
        return shadow[r];
    endfunction

    task automatic commit(input reg_addr_t a0, input logic [W-1:0] d0,
                          input reg_addr_t a1, input logic [W-1:0] d1);
        @(posedge clk_i);
        we_i       <= 2'b11;
        waddr_i[0] <= a0;
        wdata_i[0] <= d0;
        waddr_i[1] <= a1;
        wdata_i[1] <= d1;
        @(posedge clk_i);
        we_i <= '0;
        // port 1 wins a collision
        if (a0 != 0) shadow[a0] = d0;
        if (a1 != 0) shadow[a1] = d1;
    endtask

    task automatic set_clobber(input reg_addr_t r, input fu_t f);
        @(posedge clk_i);
        rd_clobber_i[r] <= f;
    endtask

    task automatic drive_instr(input fu_t fu, input reg_addr_t rs1, input reg_addr_t rs2,
                               input reg_addr_t rd, input logic [3:0] flags);
        logic [W-1:0] r;
        @(posedge clk_i);
        r = $random(seed);
        issue_valid_i    <= 1'b1;
        issue_fu_i       <= fu;
        issue_rs1_i      <= rs1;
        issue_rs2_i      <= rs2;
        issue_rd_i       <= rd;
        issue_op_i       <= r[7:0];
        issue_trans_id_i <= r[10:8];
        issue_imm_i      <= $random(seed);
        issue_pc_i       <= $random(seed);
        // flags are {use_imm, use_pc, use_zimm, ex_valid}
        issue_use_imm_i  <= flags[3];
        issue_use_pc_i   <= flags[2];
        issue_use_zimm_i <= flags[1];
        issue_ex_valid_i <= flags[0];
    endtask

    // one instruction for one cycle and a check of the pulse and data that follow
    task automatic issue_check(input string name, input fu_t fu, input reg_addr_t rs1,
                               input reg_addr_t rs2, input reg_addr_t rd,
                               input logic [3:0] flags, input logic flush,
                               input logic commit_rd, input logic exp_ack);
        logic [W-1:0] exp_a;
        logic [W-1:0] exp_b;
        logic [W-1:0] wd;
        logic [W-1:0] imm;
        logic [W-1:0] pc;
        op_t op;
        trans_id_t tid;
        logic [4:0] exp_valid;
        wd = $random(seed);
        drive_instr(fu, rs1, rs2, rd, flags);
        flush_i <= flush;
        if (commit_rd) begin
            we_i[0]    <= 1'b1;
            waddr_i[0] <= rd;
            wdata_i[0] <= wd;
        end
        @(negedge clk_i);
        imm = issue_imm_i;
        pc  = issue_pc_i;
        op  = issue_op_i;
        tid = issue_trans_id_i;
        exp_a = source_value(0, rs1);
        exp_b = source_value(1, rs2);
        if (flags[2]) exp_a = pc;
        if (flags[1]) exp_a = {27'b0, rs1};
        if (flags[3] && fu != STORE && fu != CTRL_FLOW) exp_b = imm;
        check({name, " ack"}, exp_ack, issue_ack_o);
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
        flush_i       <= 1'b0;
        we_i          <= '0;
        if (commit_rd && rd != 0) shadow[rd] = wd;
        exp_valid = (exp_ack && !flags[0] && !flush) ? unit_valid(fu) : 5'b0;
        @(negedge clk_i);
        check({name, " valid"}, exp_valid,
              {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o});
        if (exp_valid != 0) begin
            check({name, " operand_a"}, exp_a, operand_a_o);
            check({name, " operand_b"}, exp_b, operand_b_o);
            check({name, " imm"}, imm, imm_o);
            check({name, " pc"}, pc, pc_o);
            check({name, " fu"}, fu, fu_o);
            check({name, " op"}, op, op_o);
            check({name, " trans_id"}, tid, trans_id_o);
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial begin
        logic [W-1:0] d;
        reg_addr_t ra;
        reg_addr_t rb;
        rst_ni <= 1'b0;
        flush_i <= 1'b0;
        issue_valid_i <= 1'b0;
        issue_fu_i <= NONE;
        issue_op_i <= '0;
        issue_rs1_i <= '0;
        issue_rs2_i <= '0;
        issue_rd_i <= '0;
        issue_imm_i <= '0;
        issue_pc_i <= '0;
        issue_use_imm_i <= 1'b0;
        issue_use_pc_i <= 1'b0;
        issue_use_zimm_i <= 1'b0;
        issue_ex_valid_i <= 1'b0;
        issue_trans_id_i <= '0;
        for (int i = 0; i < NR_REGS; i++) begin
            rd_clobber_i[i] <= NONE;
            shadow[i] = '0;
        end
        fwd_data_i <= '0;
        fwd_valid_i <= '0;
        flu_ready_i <= 1'b1;
        lsu_ready_i <= 1'b1;
        waddr_i <= '0;
        wdata_i <= '0;
        we_i <= '0;
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;

        // register file with a collision on x7
        commit(5, $random(seed), 6, $random(seed));
        commit(7, $random(seed), 7, $random(seed));
        issue_check("rf_read", ALU, 5, 6, 1, 4'b0000, 0, 0, 1);
        issue_check("rf_collision", ALU, 7, 0, 1, 4'b0000, 0, 0, 1);

        // x0 ignores writes and clobber entries
        commit(0, $random(seed), 0, $random(seed));
        set_clobber(0, LOAD);
        issue_check("rf_zero", ALU, 0, 0, 1, 4'b0000, 0, 0, 1);
        set_clobber(0, NONE);

        // forwarding on both sources, then stalls
        set_clobber(5, ALU);
        d = $random(seed);
        fwd_data_i[0] <= d;
        fwd_data_i[1] <= $random(seed);
        fwd_valid_i <= 2'b11;
        issue_check("fwd_alu", ALU, 5, 5, 2, 4'b0000, 0, 0, 1);
        fwd_valid_i <= 2'b00;
        issue_check("fwd_not_ready", ALU, 6, 5, 2, 4'b0000, 0, 0, 0);
        set_clobber(5, CSR);
        fwd_valid_i[0] <= 1'b1;
        issue_check("fwd_csr", ALU, 5, 6, 2, 4'b0000, 0, 0, 0);
        fwd_valid_i[0] <= 1'b0;
        issue_check("zimm_clobbered", CSR, 5, 0, 2, 4'b0010, 0, 0, 1);
        issue_check("ex_stalled", ALU, 5, 6, 2, 4'b0001, 0, 0, 1);
        issue_check("none_stalled", NONE, 5, 6, 2, 4'b0000, 0, 0, 1);
        set_clobber(5, NONE);

        // unit readiness
        flu_ready_i <= 1'b0;
        issue_check("flu_alu", ALU, 5, 6, 2, 4'b0000, 0, 0, 0);
        issue_check("flu_branch", CTRL_FLOW, 5, 6, 2, 4'b0000, 0, 0, 0);
        issue_check("flu_csr", CSR, 5, 6, 2, 4'b0000, 0, 0, 0);
        issue_check("flu_mult", MULT, 5, 6, 2, 4'b0000, 0, 0, 0);
        issue_check("flu_load", LOAD, 5, 6, 2, 4'b0000, 0, 0, 1);
        issue_check("flu_none", NONE, 5, 6, 2, 4'b0000, 0, 0, 1);
        issue_check("flu_ex", ALU, 5, 6, 2, 4'b0001, 0, 0, 1);
        flu_ready_i <= 1'b1;
        lsu_ready_i <= 1'b0;
        issue_check("lsu_load", LOAD, 5, 6, 2, 4'b0000, 0, 0, 0);
        issue_check("lsu_store", STORE, 5, 6, 2, 4'b0000, 0, 0, 0);
        lsu_ready_i <= 1'b1;

        // write after write on x9
        set_clobber(9, LOAD);
        issue_check("waw_block", ALU, 5, 6, 9, 4'b0000, 0, 0, 0);
        issue_check("waw_commit", ALU, 5, 6, 9, 4'b0000, 0, 1, 1);
        set_clobber(9, NONE);

        // operand overrides and routing
        issue_check("use_pc", ALU, 5, 6, 3, 4'b0100, 0, 0, 1);
        issue_check("zimm_over_pc", CSR, 21, 6, 3, 4'b0110, 0, 0, 1);
        issue_check("use_imm", ALU, 5, 6, 3, 4'b1000, 0, 0, 1);
        issue_check("store_imm", STORE, 5, 6, 0, 4'b1000, 0, 0, 1);
        issue_check("branch_imm", CTRL_FLOW, 5, 6, 0, 4'b1100, 0, 0, 1);
        issue_check("load", LOAD, 7, 0, 4, 4'b1000, 0, 0, 1);
        issue_check("mult", MULT, 5, 7, 4, 4'b0000, 0, 0, 1);
        issue_check("flush", ALU, 5, 6, 4, 4'b0000, 1, 0, 1);

        // multiply blocks everything but another multiply
        drive_instr(MULT, 5, 6, 8, 4'b0000);
        @(negedge clk_i);
        check("mult_first ack", 1, issue_ack_o);
        drive_instr(ALU, 5, 6, 8, 4'b0000);
        @(negedge clk_i);
        check("alu_after_mult ack", 0, issue_ack_o);
        drive_instr(MULT, 5, 6, 8, 4'b0000);
        @(negedge clk_i);
        check("mult_again ack", 1, issue_ack_o);
        drive_instr(MULT, 6, 5, 8, 4'b0000);
        @(negedge clk_i);
        check("mult_after_mult ack", 1, issue_ack_o);
        @(posedge clk_i);
        issue_valid_i <= 1'b0;

        // random commits and ALU reads
        for (int n = 0; n < 20; n++) begin
            ra = $random(seed);
            rb = $random(seed);
            commit(ra, $random(seed), rb, $random(seed));
            d = $random(seed);
            issue_check("random", ALU, rb, ra, d[4:0], {d[8:7], 2'b00}, 0, 0, 1);
        end

        repeat (2) @(posedge clk_i);
        if (i_issue_read_operands.i_issue_read_operands_assert.fail_count != 0) begin
            $display("one or more bound assertions failed");
            $display("RESULT: FAIL");
            $fatal(1, "assertion failure");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/issue_pkg.sv
logic/int_regfile.sv
logic/operand_fetch.sv
logic/issue_control.sv
logic/issue_read_operands.sv
test/issue_read_operands_assert.sv
test/tb_issue_read_operands.sv

// ==== Makefile ====
# Verilator build and run of the issue stage testbench

VERILATOR  ?= verilator
TOP        ?= tb_issue_read_operands
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
RUN_ARGS   ?= +verilator+error+limit+100
PASS_TEXT  ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
